// ==== build.f ====
pa_word_pkg.sv
pa_ctrl_pkg.sv
pa_bus_w.sv
pa_regs.sv
pa_alu.sv
pa_addr.sv
pa.sv
tb_pa_asserts.sv
tb_pa.sv

// ==== run.sh ====
#!/bin/sh
# compile with verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_pa -f build.f -o tb_pa_sim \
	&& ./obj_dir/tb_pa_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q '^>>> PASS$' sim.log 2>/dev/null && echo "run.sh: simulation passed" && exit 0 \
	|| { echo "run.sh: simulation failed"; exit 1; }

// ==== tb_pa.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pa;

	import pa_word_pkg::*;
	import pa_ctrl_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int N_ROWS = 29;
	localparam int N_RAND = 200;
	localparam int SEED = 90;
	localparam int LIMIT = 2 * (N_ROWS + N_RAND + RESET_CYCLES);

	// control bits of a row with w_dt in bit 0
	localparam logic [13:0] DT  = 14'h0001;
	localparam logic [13:0] LAC = 14'h0002;
	localparam logic [13:0] LAR = 14'h0004;
	localparam logic [13:0] LIC = 14'h0008;
	localparam logic [13:0] LAT = 14'h0010;
	localparam logic [13:0] LWZ = 14'h0020;
	localparam logic [13:0] P1  = 14'h0040;
	localparam logic [13:0] M4  = 14'h0080;
	localparam logic [13:0] IP  = 14'h0100;
	localparam logic [13:0] OFF = 14'h0200;
	localparam logic [13:0] CI  = 14'h0400;
	localparam logic [13:0] RA  = 14'h0800;
	localparam logic [13:0] RI  = 14'h1000;
	localparam logic [13:0] BN  = 14'h2000;

	// stimulus followed by expected w, f, carry, zs, dad and zga
	typedef struct packed {
		w_src_t w_sel;
		a_src_t a_sel;
		alu_op_t op;
		logic [13:0] en;
		word_t ir;
		word_t l;
		word_t kl;
		word_t xw;
		word_t xf;
		logic xc;
		logic xz;
		word_t xdad;
		logic xzga;
	} row_t;

	localparam row_t TBL [N_ROWS] = '{
		'{W_AC, A_IR, OP_PASS, RA|RI, 'h0, 'h0, 'h0, 'h0, 'h0, 0, 1, 'h0, 1},
		'{W_AT, A_IR, OP_PASS, RA|BN, 'h0, 'h0, 'h0, 'h0, 'h0, 0, 1, 'h0, 0},
		'{W_NONE, A_IR, OP_PASS, RI|BN, 'h0, 'h0, 'h8000, 'h0, 'h0, 0, 1, 'h0, 1},
		'{W_IR, A_IR, OP_PASS, DT, 'hA5A5, 'h0, 'h0, 'hA5A5, 'hA5A5, 0, 0, 'h0, 1},
		'{W_KI, A_L, OP_PASS, 0, 'h0, 'h00FF, 'h0, 'h1234, 'h00FF, 0, 0, 'h0, 1},
		'{W_RDT, A_IR, OP_PASS, DT, 'h0, 'h0, 'h0, 'h5678, 'h0, 0, 1, 'h0, 1},
		'{W_KL, A_IR, OP_PASS, DT|LAC, 'h0, 'h0, 'h0F0F, 'h0F0F, 'h0, 0, 1, 'h0, 0},
		'{W_AC, A_L, OP_AND, LAT|LWZ, 'h0, 'h00F0, 'h0, 'h0F0F, 'h0, 0, 1, 'h0, 1},
		'{W_AT, A_L, OP_OR, LAT, 'h0, 'h00F0, 'h0, 'h0, 'h0FFF, 0, 0, 'h0, 1},
		'{W_AT, A_L, OP_XOR, LAT|LWZ, 'h0, 'hFFFF, 'h0, 'h0FFF, 'hF0F0, 0, 0, 'h0, 1},
		'{W_A, A_L, OP_PASS, LAR, 'h0, 'h1111, 'h0, 'h1111, 'h1111, 0, 0, 'h0, 1},
		'{W_IR, A_IR, OP_ADD, LAC|LAT, 'hFFFF, 'h0, 'h0, 'hFFFF, 'h0F0E, 1, 0, 'h0, 1},
		'{W_NONE, A_L, OP_ADD, LAT|LWZ, 'h0, 'h0001, 'h0, 'h0, 'h0, 1, 1, 'h0, 1},
		'{W_KL, A_AR, OP_SUB, LAC|LAT, 'h0, 'h0, 'h0010, 'h0010, 'hEEEE, 1, 0, 'h0, 0},
		'{W_NONE, A_L, OP_SUB, LWZ|CI, 'h0, 'h0020, 'h0, 'h0, 'hFFF0, 0, 0, 'h0, 1},
		'{W_NONE, A_L, OP_SUB, LWZ, 'h0, 'h0010, 'h0, 'h0, 'h0, 1, 1, 'h0, 1},
		'{W_NONE, A_L, OP_ADD, LAT|CI, 'h0, 'h0005, 'h0, 'h0, 'h0016, 0, 0, 'h0, 1},
		'{W_IR, A_IR, OP_PASS, LAR|P1|M4|RA, 'h2, 'h0, 'h1111, 'h2, 'h2, 0, 0, 'h1111, 1},
		'{W_NONE, A_IR, OP_PASS, P1|M4|RA, 'h0, 'h0, 'h0, 'h0, 'h0, 0, 1, 'h0002, 0},
		'{W_NONE, A_IR, OP_PASS, M4|RA, 'h0, 'h0, 'h0, 'h0, 'h0, 0, 1, 'h0003, 0},
		'{W_A, A_AR, OP_PASS, LIC|RA|BN, 'h0, 'h0, 'hFFFF, 'hFFFF, 'hFFFF, 0, 0, 'hFFFF, 1},
		'{W_NONE, A_IR, OP_PASS, IP|RI, 'h0, 'h0, 'h7FFF, 'h0, 'h0, 0, 1, 'hFFFF, 1},
		'{W_KI, A_IR, OP_PASS, LIC|IP|RA|RI, 'h0, 'h0, 'h0, 'h1234, 'h0, 0, 1, 'hFFFF, 0},
		'{W_RDT, A_IC, OP_PASS, OFF|LIC|IP|RI, 'h0, 'h0, 'h1234, 'h5678, 'h1234, 0, 0, 'h1234, 1},
		'{W_KL, A_IR, OP_PASS, LAR|IP|RI, 'h0, 'h0, 'h0F00, 'h0F00, 'h0, 0, 1, 'h0, 0},
		'{W_NONE, A_IR, OP_PASS, RA|RI|BN, 'h0, 'h0, 'h8F01, 'h0, 'h0, 0, 1, 'h0F01, 1},
		'{W_IR, A_IR, OP_PASS, LAR|M4, 'h00FF, 'h0, 'h0, 'h00FF, 'h00FF, 0, 0, 'h0, 1},
		'{W_NONE, A_AR, OP_PASS, P1|RA, 'h0, 'h0, 'h0, 'h0, 'h00FF, 0, 0, 'h00FF, 0},
		'{W_NONE, A_IR, OP_PASS, M4, 'h0, 'h0, 'h0, 'h0, 'h0, 0, 1, 'h0, 1}
	};

	logic __clk = 1'b0;
	logic arst_n;
	word_t ir, ki, rdt, kl, l;
	w_src_t w_sel;
	a_src_t a_sel;
	alu_op_t alu_op;
	logic w_dt, w_ac, w_ar, w_ic, w_at, w_wzi;
	logic arp1, arm4, icp1, off, carry_in, ar_ad, ic_ad, barnb;
	word_t w, ddt, f, at, dad;
	logic carry, zs, wzi, arz, zga;

	// register copies kept by the model
	word_t m_ac = '0;
	word_t m_ar = '0;
	word_t m_ic = '0;
	word_t m_at = '0;
	logic m_wzi = 1'b0;
	int cycles = 0;

	pa i_dut (.*);

	always #5 __clk = ~__clk;

	always @(posedge __clk) begin
		cycles = cycles + 1;
		if (cycles > LIMIT) begin
			$display(">>> FAIL");
			$fatal(1, "timeout, the tests did not finish within %0d cycles", LIMIT);
		end
	end

	task automatic check(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic update_model(input row_t r);
		if (|(r.en & LAC))
			m_ac = r.xw;
		if (|(r.en & LAT))
			m_at = r.xf;
		if (|(r.en & LWZ))
			m_wzi = r.xz;
		// load beats +1 and +1 beats -4
		if (|(r.en & LAR))
			m_ar = r.xw;
		else if (|(r.en & P1))
			m_ar = m_ar + 16'd1;
		else if (|(r.en & M4))
			m_ar = m_ar - 16'd4;
		if (|(r.en & OFF))
			m_ic = '0;
		else if (|(r.en & LIC))
			m_ic = r.xw;
		else if (|(r.en & IP))
			m_ic = m_ic + 16'd1;
	endtask

	task automatic apply_row(input row_t r);
		@(negedge __clk);
		w_sel = r.w_sel;
		a_sel = r.a_sel;
		alu_op = r.op;
		ir = r.ir;
		l = r.l;
		kl = r.kl;
		{barnb, ic_ad, ar_ad, carry_in, off, icp1, arm4, arp1,
			w_wzi, w_at, w_ic, w_ar, w_ac, w_dt} = r.en;
		// combinational paths settle well before the edge
		#4;
		check(w, r.xw, "w");
		check(ddt, |(r.en & DT) ? r.xw : 16'h0000, "ddt");
		check(f, r.xf, "f");
		check(16'(carry), 16'(r.xc), "carry");
		check(16'(zs), 16'(r.xz), "zs");
		check(dad, r.xdad, "dad");
		check(16'(zga), 16'(r.xzga), "zga");
		@(posedge __clk);
		update_model(r);
		#1;
		check(at, m_at, "at");
		check(16'(wzi), 16'(m_wzi), "wzi");
		check(16'(arz), 16'(|m_ar[0:HI_BYTE_LAST]), "arz");
	endtask

	// add or subtract with l as the a operand and ir loaded into ac
	function automatic row_t random_row(input logic [31:0] words, input logic [31:0] ctl,
			input word_t ac_now);
		row_t r;
		logic [16:0] sum;
		r.w_sel = W_IR;
		r.a_sel = A_L;
		r.op = ctl[0] ? OP_SUB : OP_ADD;
		r.en = LAC | LAT | LWZ;
		if (ctl[1])
			r.en = r.en | CI;
		r.ir = words[31:16];
		r.l = words[15:0];
		r.kl = '0;
		r.xw = r.ir;
		if (ctl[0]) begin
			// carry set means no borrow
			r.xf = ac_now - r.l;
			r.xc = (ac_now >= r.l);
		end else begin
			sum = {1'b0, ac_now} + {1'b0, r.l} + 17'(ctl[1]);
			r.xf = sum[15:0];
			r.xc = sum[16];
		end
		r.xz = (r.xf == '0);
		r.xdad = '0;
		r.xzga = 1'b1;
		return r;
	endfunction

	initial begin
		logic [31:0] words;
		logic [31:0] ctl;
		void'($urandom(SEED));
		arst_n = 1'b0;
		ir = '0;
		ki = 16'h1234;
		rdt = 16'h5678;
		kl = '0;
		l = '0;
		w_sel = W_NONE;
		a_sel = A_IR;
		alu_op = OP_PASS;
		{barnb, ic_ad, ar_ad, carry_in, off, icp1, arm4, arp1,
			w_wzi, w_at, w_ic, w_ar, w_ac, w_dt} = '0;
		repeat (RESET_CYCLES) @(posedge __clk);
		@(negedge __clk);
		arst_n = 1'b1;
		check(at, '0, "at after reset");
		check(16'(wzi), 16'h0000, "wzi after reset");
		check(16'(arz), 16'h0000, "arz after reset");

		for (int i = 0; i < N_ROWS; i++) begin
			apply_row(TBL[i]);
		end

		for (int n = 0; n < N_RAND; n++) begin
			words = $urandom;
			ctl = $urandom;
			apply_row(random_row(words, ctl, m_ac));
		end

		if (i_dut.i_regs.i_asserts.fail_count != 0) begin
			$display(">>> FAIL");
			$fatal(1, "register bank assertions failed");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb_pa_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pa_asserts (
	input wire __clk,
	input wire arst_n,
	input wire off,
	input wire pa_word_pkg::word_t ic,
	input wire w_ar,
	input wire arp1,
	input wire arm4,
	input wire pa_word_pkg::word_t ar,
	input wire w_at,
	input wire pa_word_pkg::word_t at,
	input wire pa_word_pkg::word_t f
);

	int fail_count = 0;

	// off clears the instruction counter
	a_off_clears_ic: assert property (@(posedge __clk) disable iff (!arst_n)
		off |=> ic == '0)
	else begin
		$error("ic not zero after off");
		fail_count++;
	end

	a_ar_holds: assert property (@(posedge __clk) disable iff (!arst_n)
		!w_ar && !arp1 && !arm4 |=> $stable(ar))
	else begin
		$error("ar changed without load, +1 or -4");
		fail_count++;
	end

	// at picks up the alu result of the cycle before
	a_at_takes_f: assert property (@(posedge __clk) disable iff (!arst_n)
		w_at |=> at == $past(f))
	else begin
		$error("at does not hold the previous f");
		fail_count++;
	end

endmodule

bind pa_regs tb_pa_asserts i_asserts (
	.__clk(__clk), .arst_n(arst_n), .off(off), .ic(ic),
	.w_ar(w_ar), .arp1(arp1), .arm4(arm4), .ar(ar),
	.w_at(w_at), .at(at), .f(f)
);

`default_nettype wire

// ==== pa.sv ====
`timescale 1ns/100ps
`default_nettype none

module pa (
	input  wire __clk,
	input  wire arst_n,
	input  wire pa_word_pkg::word_t ir,
	input  wire pa_word_pkg::word_t ki,
	input  wire pa_word_pkg::word_t rdt,
	input  wire pa_word_pkg::word_t kl,
	input  wire pa_word_pkg::word_t l,
	input  wire pa_ctrl_pkg::w_src_t w_sel,
	input  wire pa_ctrl_pkg::a_src_t a_sel,
	input  wire pa_ctrl_pkg::alu_op_t alu_op,
	input  wire w_dt,
	input  wire w_ac,
	input  wire w_ar,
	input  wire w_ic,
	input  wire w_at,
	input  wire w_wzi,
	input  wire arp1,
	input  wire arm4,
	input  wire icp1,
	input  wire off,
	input  wire carry_in,
	input  wire ar_ad,
	input  wire ic_ad,
	input  wire barnb,
	output wire pa_word_pkg::word_t w,
	output wire pa_word_pkg::word_t ddt,
	output wire pa_word_pkg::word_t f,
	output wire pa_word_pkg::word_t at,
	output wire pa_word_pkg::word_t dad,
	output wire carry,
	output wire zs,
	output wire wzi,
	output wire arz,
	output wire zga
);

	import pa_word_pkg::*;

	// registers and a bus internal to the slice
	word_t ac;
	word_t ar;
	word_t ic;
	word_t a;

	pa_bus_w i_bus_w (
		.w_sel(w_sel), .w_dt(w_dt),
		.ir(ir), .ki(ki), .rdt(rdt), .kl(kl),
		.at(at), .ac(ac), .a(a),
		.w(w), .ddt(ddt)
	);

	pa_regs i_regs (
		.__clk(__clk), .arst_n(arst_n),
		.w(w), .f(f), .zs(zs), .l(l), .ir(ir),
		.w_ac(w_ac), .w_ar(w_ar), .w_ic(w_ic), .w_at(w_at), .w_wzi(w_wzi),
		.arp1(arp1), .arm4(arm4), .icp1(icp1), .off(off),
		.a_sel(a_sel),
		.ac(ac), .ar(ar), .ic(ic), .at(at), .a(a),
		.wzi(wzi), .arz(arz)
	);

	pa_alu i_alu (
		.a(a), .ac(ac), .alu_op(alu_op), .carry_in(carry_in),
		.f(f), .carry(carry), .zs(zs)
	);

	pa_addr i_addr (
		.ar(ar), .ic(ic), .kl(kl),
		.ar_ad(ar_ad), .ic_ad(ic_ad), .barnb(barnb),
		.dad(dad), .zga(zga)
	);

endmodule

`default_nettype wire

// ==== pa_addr.sv ====
`timescale 1ns/100ps
`default_nettype none

module pa_addr (
	input  wire pa_word_pkg::word_t ar,
	input  wire pa_word_pkg::word_t ic,
	input  wire pa_word_pkg::word_t kl,
	input  wire ar_ad,
	input  wire ic_ad,
	input  wire barnb,
	output pa_word_pkg::word_t dad,
	output logic zga
);

	import pa_word_pkg::*;

	word_t dad_ar;
	word_t dad_ic;

	// both sources may be on at once, the bus ORs them
	assign dad_ar = ar & {WORD_W{ar_ad}};
	assign dad_ic = ic & {WORD_W{ic_ad}};
	assign dad = dad_ar | dad_ic;

	// key address match, barnb replaces the top address bit
	assign zga = (dad[1:WORD_W-1] == kl[1:WORD_W-1]) && (kl[0] == barnb);

endmodule

`default_nettype wire

// ==== pa_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module pa_alu (
	input  wire pa_word_pkg::word_t a,
	input  wire pa_word_pkg::word_t ac,
	input  wire pa_ctrl_pkg::alu_op_t alu_op,
	input  wire carry_in,
	output pa_word_pkg::word_t f,
	output logic carry,
	output logic zs
);

	import pa_word_pkg::*;
	import pa_ctrl_pkg::*;

	// adder operand and carry in, a inverted for subtract
	word_t add_b;
	logic add_ci;
	// bit 0 is the carry out, bits 1..16 the sum
	logic [0:WORD_W] sum;

	always_comb begin
		if (alu_op == OP_SUB) begin
			add_b = ~a;
			add_ci = 1'b1;
		end else begin
			add_b = a;
			add_ci = carry_in;
		end
	end

	// shared 17-bit adder
	assign sum = {1'b0, ac} + {1'b0, add_b} + {{WORD_W{1'b0}}, add_ci};

	always_comb begin
		f = a;
		carry = 1'b0;
		case (alu_op)
			OP_ADD, OP_SUB: begin
				// for sub, carry set means no borrow
				f = sum[1:WORD_W];
				carry = sum[0];
			end
			OP_AND: begin
				f = a & ac;
			end
			OP_OR: begin
				f = a | ac;
			end
			OP_XOR: begin
				f = a ^ ac;
			end
			default: begin
				f = a;
			end
		endcase
	end

	// zero result
	assign zs = ~|f;

endmodule

`default_nettype wire

// ==== pa_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module pa_regs (
	input  wire __clk,
	input  wire arst_n,
	input  wire pa_word_pkg::word_t w,
	input  wire pa_word_pkg::word_t f,
	input  wire zs,
	input  wire pa_word_pkg::word_t l,
	input  wire pa_word_pkg::word_t ir,
	input  wire w_ac,
	input  wire w_ar,
	input  wire w_ic,
	input  wire w_at,
	input  wire w_wzi,
	input  wire arp1,
	input  wire arm4,
	input  wire icp1,
	input  wire off,
	input  wire pa_ctrl_pkg::a_src_t a_sel,
	output pa_word_pkg::word_t ac,
	output pa_word_pkg::word_t ar,
	output pa_word_pkg::word_t ic,
	output pa_word_pkg::word_t at,
	output pa_word_pkg::word_t a,
	output logic wzi,
	output logic arz
);

	import pa_word_pkg::*;
	import pa_ctrl_pkg::*;

	// accumulator, loaded from w only
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ac <= '0;
		end else if (w_ac) begin
			ac <= w;
		end
	end

	// at holds the alu result
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			at <= '0;
		end else if (w_at) begin
			at <= f;
		end
	end

	// address register: load, then +1, then -4
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ar <= '0;
		end else if (w_ar) begin
			ar <= w;
		end else if (arp1) begin
			ar <= ar + WORD_W'(1);
		end else if (arm4) begin
			ar <= ar - WORD_W'(4);
		end
	end

	// instruction counter, off wins over everything
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ic <= '0;
		end else if (off) begin
			ic <= '0;
		end else if (w_ic) begin
			ic <= w;
		end else if (icp1) begin
			ic <= ic + WORD_W'(1);
		end
	end

	// adder zero indicator
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			wzi <= 1'b0;
		end else if (w_wzi) begin
			wzi <= zs;
		end
	end

	// any bit set in the upper byte of ar
	assign arz = |ar[0:HI_BYTE_LAST];

	// a bus into the alu
	always_comb begin
		case (a_sel)
			A_IR:    a = ir;
			A_L:     a = l;
			A_AR:    a = ar;
			default: a = ic;
		endcase
	end

endmodule

`default_nettype wire

// ==== pa_bus_w.sv ====
`timescale 1ns/100ps
`default_nettype none

module pa_bus_w (
	input  wire pa_ctrl_pkg::w_src_t w_sel,
	input  wire w_dt,
	input  wire pa_word_pkg::word_t ir,
	input  wire pa_word_pkg::word_t ki,
	input  wire pa_word_pkg::word_t rdt,
	input  wire pa_word_pkg::word_t kl,
	input  wire pa_word_pkg::word_t at,
	input  wire pa_word_pkg::word_t ac,
	input  wire pa_word_pkg::word_t a,
	output pa_word_pkg::word_t w,
	output pa_word_pkg::word_t ddt
);

	import pa_word_pkg::*;
	import pa_ctrl_pkg::*;

	// one source per transfer
	always_comb begin
		case (w_sel)
			W_IR:    w = ir;
			W_KI:    w = ki;
			W_RDT:   w = rdt;
			W_KL:    w = kl;
			W_AT:    w = at;
			W_AC:    w = ac;
			W_A:     w = a;
			default: w = '0;
		endcase
	end

	// memory data out only while w_dt is up
	assign ddt = w & {WORD_W{w_dt}};

endmodule

`default_nettype wire

// ==== pa_ctrl_pkg.sv ====
`default_nettype none

package pa_ctrl_pkg;

	// w bus source select
	typedef enum logic [2:0] {
		W_IR   = 3'd0,
		W_KI   = 3'd1,
		W_RDT  = 3'd2,
		W_KL   = 3'd3,
		W_AT   = 3'd4,
		W_AC   = 3'd5,
		W_A    = 3'd6,
		// nothing on the bus, w reads zero
		W_NONE = 3'd7
	} w_src_t;

	// a bus source select
	typedef enum logic [1:0] {
		A_IR = 2'd0,
		A_L  = 2'd1,
		A_AR = 2'd2,
		A_IC = 2'd3
	} a_src_t;

	// alu operation, codes 6 and 7 unused
	typedef enum logic [2:0] {
		OP_PASS = 3'd0,
		OP_ADD  = 3'd1,
		OP_SUB  = 3'd2,
		OP_AND  = 3'd3,
		OP_OR   = 3'd4,
		OP_XOR  = 3'd5
	} alu_op_t;

endpackage

`default_nettype wire

// ==== pa_word_pkg.sv ====
`default_nettype none

package pa_word_pkg;

	// machine word width
	localparam int WORD_W = 16;

	// last bit of the upper byte, bit 0 being the msb
	localparam int HI_BYTE_LAST = 7;

	// one machine word, numbered 0 (msb) to 15 (lsb)
	typedef logic [0:WORD_W-1] word_t;

endpackage

`default_nettype wire
